/* tb.f */
+incdir+.
dcache_pkg.sv
plru_way_select.sv
cache_way.sv
way_merge.sv
dcache.sv
dcache_chk.sv
dcache_tb.sv

/* Makefile */
# Verilator build and run for the dcache testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module dcache_tb -f tb.f -o dcache_sim

# pass only if the log holds the pass line
run: compile
	./obj_dir/dcache_sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dcache_tb.sv */
// dcache_tb: drives the cache ports and compares them against a model of lines and tree bits
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb;

  localparam int CLK_PERIOD = 100;
  localparam int RANDOM_OPS = 400;
  // about 420 cycles of reset and tests, with ample margin
  localparam int TIMEOUT_CYCLES = 1200;

  typedef struct packed {
    logic                         rd_hit;
    logic [`DCACHE_DATA_BITS-1:0] rd_data;
    logic                         wr_hit;
    dcache_pkg::dcache_victim_t   victim;
  } expect_t;

  logic                         clock;
  logic                         reset;
  dcache_pkg::dcache_addr_u     rd_addr;
  logic                         rd_search;
  dcache_pkg::dcache_write_t    wr_req;
  logic                         wr_en;
  logic                         wr_from_mem;
  logic                         wr_search;
  logic                         rd_hit;
  logic [`DCACHE_DATA_BITS-1:0] rd_data;
  logic                         wr_hit;
  dcache_pkg::dcache_victim_t   victim;

  // reference lines per way and set, tree bits per set
  dcache_pkg::dcache_line_t    model_line [`DCACHE_NUM_WAY][`DCACHE_NUM_SETS];
  logic [`DCACHE_NUM_SETS-1:0] model_a;
  logic [`DCACHE_NUM_SETS-1:0] model_b;
  logic [`DCACHE_NUM_SETS-1:0] model_c;

  string       test_name;
  int          value_errors;
  int          other_errors;
  int          cycle_count;
  logic [31:0] rng_state;
  expect_t     exp_out;

  dcache u_dcache (
    .clock       (clock),
    .reset       (reset),
    .rd_addr     (rd_addr),
    .rd_search   (rd_search),
    .wr_req      (wr_req),
    .wr_en       (wr_en),
    .wr_from_mem (wr_from_mem),
    .wr_search   (wr_search),
    .rd_hit      (rd_hit),
    .rd_data     (rd_data),
    .wr_hit      (wr_hit),
    .victim      (victim)
  );

  bind dcache dcache_chk u_chk (
    .clock      (clock),
    .reset      (reset),
    .way_wr_en  (way_wr_en),
    .way_rd_hit (way_rd_hit),
    .wr_search  (wr_search),
    .victim     (victim)
  );

  always #(CLK_PERIOD / 2) clock = !clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic dcache_pkg::dcache_addr_u make_addr(input logic [`DCACHE_TAG_BITS-1:0] tag,
      input logic [`DCACHE_INDEX_BITS-1:0] idx, input logic [`DCACHE_OFFSET_BITS-1:0] off);
    dcache_pkg::dcache_addr_u a;
    a.fields.tag       = tag;
    a.fields.set_index = idx;
    a.fields.offset    = off;
    return a;
  endfunction

  function automatic dcache_pkg::dcache_write_t make_write(input logic [`DCACHE_TAG_BITS-1:0] tag,
      input logic [`DCACHE_INDEX_BITS-1:0] idx, input logic [`DCACHE_DATA_BITS-1:0] data,
      input logic dirty);
    dcache_pkg::dcache_write_t w;
    w.addr  = make_addr(tag, idx, '0);
    w.data  = data;
    w.valid = 1'b1;
    w.dirty = dirty;
    return w;
  endfunction

  // a picks the half, then c or b picks the way
  function automatic logic [1:0] plru_victim(input logic [`DCACHE_INDEX_BITS-1:0] s);
    if (model_a[s]) begin
      return model_c[s] ? 2'd3 : 2'd2;
    end
    return model_b[s] ? 2'd1 : 2'd0;
  endfunction

  function automatic expect_t model_outputs(input dcache_pkg::dcache_addr_u ra, input logic rs,
      input dcache_pkg::dcache_write_t wq, input logic ws);
    expect_t                       e;
    dcache_pkg::dcache_line_t      ln;
    logic [`DCACHE_DATA_BITS-1:0]  hit_data;
    logic [`DCACHE_INDEX_BITS-1:0] wr_set;
    int                            hits;
    e        = '0;
    hit_data = '0;
    hits     = 0;
    wr_set   = wq.addr.fields.set_index;
    for (int w = 0; w < `DCACHE_NUM_WAY; w++) begin
      ln = model_line[w][ra.fields.set_index];
      if (ln.valid && ln.tag == ra.fields.tag) begin
        hits++;
        hit_data = ln.data;
      end
      ln = model_line[w][wr_set];
      if (ln.valid && ln.tag == wq.addr.fields.tag) begin
        e.wr_hit = 1'b1;
      end
    end
    e.rd_hit  = (hits > 0);
    e.rd_data = (rs && hits == 1) ? hit_data : `DCACHE_MISS_DATA;
    if (ws) begin
      ln             = model_line[plru_victim(wr_set)][wr_set];
      e.victim.valid = ln.valid;
      e.victim.dirty = ln.dirty;
      e.victim.addr  = make_addr(ln.tag, wr_set, '0);
      e.victim.data  = ln.data;
    end
    return e;
  endfunction

  // store hits rewrite the hitting way, misses from memory fill the tree's victim
  function automatic void model_write(input dcache_pkg::dcache_write_t wq, input logic we,
      input logic fm);
    dcache_pkg::dcache_line_t      ln;
    logic [`DCACHE_INDEX_BITS-1:0] s;
    logic                          hit_any;
    s        = wq.addr.fields.set_index;
    hit_any  = 1'b0;
    ln.valid = wq.valid;
    ln.dirty = wq.dirty;
    ln.tag   = wq.addr.fields.tag;
    ln.data  = wq.data;
    for (int w = 0; w < `DCACHE_NUM_WAY; w++) begin
      if (model_line[w][s].valid && model_line[w][s].tag == wq.addr.fields.tag) begin
        hit_any = 1'b1;
        if (we) begin
          model_line[w][s] = ln;
        end
      end
    end
    if (we && fm && !hit_any) begin
      model_line[plru_victim(s)][s] = ln;
      if (model_a[s]) begin
        model_c[s] = !model_c[s];
      end else begin
        model_b[s] = !model_b[s];
      end
      model_a[s] = !model_a[s];
    end
  endfunction

  // compare at the rising edge, then advance the model
  always @(posedge clock) begin
    if (reset) begin
      for (int w = 0; w < `DCACHE_NUM_WAY; w++) begin
        for (int s = 0; s < `DCACHE_NUM_SETS; s++) begin
          model_line[w][s] = '0;
        end
      end
      model_a = '0;
      model_b = '0;
      model_c = '0;
    end else begin
      exp_out = model_outputs(rd_addr, rd_search, wr_req, wr_search);
      if (rd_hit !== exp_out.rd_hit) begin
        value_errors++;
        $display("FAILED %s rd_hit expected %0b actual %0b", test_name, exp_out.rd_hit, rd_hit);
      end
      if (rd_data !== exp_out.rd_data) begin
        value_errors++;
        $display("FAILED %s rd_data expected %h actual %h", test_name, exp_out.rd_data, rd_data);
      end
      if (wr_hit !== exp_out.wr_hit) begin
        value_errors++;
        $display("FAILED %s wr_hit expected %0b actual %0b", test_name, exp_out.wr_hit, wr_hit);
      end
      if (victim !== exp_out.victim) begin
        value_errors++;
        $display("FAILED %s victim expected %h actual %h", test_name, exp_out.victim, victim);
      end
      model_write(wr_req, wr_en, wr_from_mem);
    end
  end

  task automatic print_counts();
    $display("errors: %0d value, %0d assertion, %0d other", value_errors,
             u_dcache.u_chk.fail_count, other_errors);
  endtask

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      other_errors++;
      $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      print_counts();
      $display("Something failed");
      $finish;
    end
  end

  task automatic drive(input string name, input dcache_pkg::dcache_addr_u ra, input logic rs,
      input dcache_pkg::dcache_write_t wq, input logic we, input logic fm, input logic ws);
    @(negedge clock);
    test_name   = name;
    rd_addr     = ra;
    rd_search   = rs;
    wr_req      = wq;
    wr_en       = we;
    wr_from_mem = fm;
    wr_search   = ws;
  endtask

  // hard-coded write-back candidate sampled in the middle of the cycle
  task automatic expect_victim(input string name, input dcache_pkg::dcache_addr_u addr,
      input logic valid, input logic dirty, input logic [`DCACHE_DATA_BITS-1:0] data);
    dcache_pkg::dcache_victim_t exp_v;
    #(CLK_PERIOD / 10);
    exp_v.valid = valid;
    exp_v.dirty = dirty;
    exp_v.addr  = addr;
    exp_v.data  = data;
    if (victim !== exp_v) begin
      value_errors++;
      $display("FAILED %s victim expected %h actual %h", name, exp_v, victim);
    end
  endtask

  task automatic run_directed();
    dcache_pkg::dcache_write_t wq;
    dcache_pkg::dcache_addr_u  a;
    // empty cache misses everywhere
    wq = make_write(24'h000042, 5'd0, 64'h0, 1'b0);
    drive("reset_miss", make_addr(24'h000042, 5'd0, 3'd0), 1'b1, wq, 1'b0, 1'b0, 1'b1);
    expect_victim("reset_miss", make_addr(24'h0, 5'd0, 3'd0), 1'b0, 1'b0, 64'h0);
    wq = make_write(24'h00ABCD, 5'd3, 64'h0, 1'b0);
    drive("reset_miss", make_addr(24'h00ABCD, 5'd3, 3'd4), 1'b1, wq, 1'b0, 1'b0, 1'b1);
    drive("reset_miss", make_addr(24'hFFFFFF, 5'd31, 3'd7), 1'b1, wq, 1'b0, 1'b0, 1'b0);
    // fill, read back, other tag in the same set
    wq = make_write(24'h000011, 5'd3, 64'h1111_2222_3333_4444, 1'b0);
    drive("fill_then_read", make_addr(24'h000011, 5'd3, 3'd0), 1'b1, wq, 1'b1, 1'b1, 1'b1);
    drive("fill_then_read", make_addr(24'h000011, 5'd3, 3'd0), 1'b1, '0, 1'b0, 1'b0, 1'b0);
    drive("other_tag_miss", make_addr(24'h000012, 5'd3, 3'd0), 1'b1, '0, 1'b0, 1'b0, 1'b0);
    // ways 0, 2, 1, 3, then 0 again
    for (int i = 0; i < 5; i++) begin
      a  = make_addr(24'h0000A0 + 24'(i), 5'd5, 3'd0);
      wq = make_write(24'h0000A0 + 24'(i), 5'd5, 64'h00A0_0000_0000_0000 + 64'(i), 1'b0);
      drive("plru_order", a, 1'b1, wq, 1'b1, 1'b1, 1'b1);
      if (i == 4) begin
        expect_victim("plru_order", make_addr(24'h0000A0, 5'd5, 3'd0), 1'b1, 1'b0,
                      64'h00A0_0000_0000_0000);
      end
    end
    // store hit on the next victim keeps the order
    wq = make_write(24'h0000A1, 5'd5, 64'h5704_E000_0000_00A1, 1'b1);
    drive("store_hit", make_addr(24'h0000A1, 5'd5, 3'd0), 1'b1, wq, 1'b1, 1'b0, 1'b1);
    expect_victim("store_hit", make_addr(24'h0000A1, 5'd5, 3'd0), 1'b1, 1'b0,
                  64'h00A0_0000_0000_0001);
    drive("store_read", make_addr(24'h0000A1, 5'd5, 3'd0), 1'b1, '0, 1'b0, 1'b0, 1'b0);
    wq = make_write(24'h0000B7, 5'd5, 64'hB7B7_B7B7_0000_0000, 1'b0);
    drive("dirty_victim", make_addr(24'h0000A1, 5'd5, 3'd0), 1'b1, wq, 1'b0, 1'b0, 1'b1);
    expect_victim("dirty_victim", make_addr(24'h0000A1, 5'd5, 3'd0), 1'b1, 1'b1,
                  64'h5704_E000_0000_00A1);
    // write miss without memory data is dropped
    drive("no_fill", make_addr(24'h0000B7, 5'd5, 3'd0), 1'b1, wq, 1'b1, 1'b0, 1'b1);
    drive("no_fill_after", make_addr(24'h0000B7, 5'd5, 3'd0), 1'b1, wq, 1'b0, 1'b0, 1'b1);
    expect_victim("no_fill_after", make_addr(24'h0000A1, 5'd5, 3'd0), 1'b1, 1'b1,
                  64'h5704_E000_0000_00A1);
  endtask

  task automatic run_random();
    logic [31:0]               r;
    dcache_pkg::dcache_write_t wq;
    dcache_pkg::dcache_addr_u  ra;
    logic                      we;
    logic                      fm;
    logic                      ws;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      rng_state = xorshift32(rng_state);
      r  = rng_state;
      // four sets and eight tags
      ra = make_addr({16'h0001, 5'h0, r[12:10]}, {r[9:8], 3'b001}, r[15:13]);
      wq = make_write({16'h0001, 5'h0, r[4:2]}, {r[1:0], 3'b001}, {r, r ^ 32'h5A5A_5A5A}, r[20]);
      // op 0 idles, 1 fills, 2 stores, 3 only searches
      we = (r[17:16] == 2'd1) || (r[17:16] == 2'd2);
      fm = (r[17:16] == 2'd1);
      ws = r[19] || (r[17:16] == 2'd3);
      drive("random_mix", ra, r[18], wq, we, fm, ws);
    end
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    rd_addr      = '0;
    rd_search    = 1'b0;
    wr_req       = '0;
    wr_en        = 1'b0;
    wr_from_mem  = 1'b0;
    wr_search    = 1'b0;
    test_name    = "reset";
    value_errors = 0;
    other_errors = 0;
    cycle_count  = 0;
    rng_state    = 32'd94;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    run_directed();
    run_random();
    drive("idle", '0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    @(negedge clock);
    print_counts();
    if (value_errors == 0 && other_errors == 0 && u_dcache.u_chk.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* dcache_chk.sv */
// dcache_chk: bound assertions on way write enables, read hits and the victim port
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_chk (
  input logic                       clock,
  input logic                       reset,
  input logic [`DCACHE_NUM_WAY-1:0] way_wr_en,
  input logic [`DCACHE_NUM_WAY-1:0] way_rd_hit,
  input logic                       wr_search,
  input dcache_pkg::dcache_victim_t victim
);

  // failed assertions so far
  int fail_count = 0;

  // store hit or fill, never two ways at once
  a_wr_en_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(way_wr_en))
    else begin
      fail_count++;
      $error("more than one way write enable is high");
    end

  // fills only on a miss, so a tag lives in one way
  a_rd_hit_single: assert property (@(posedge clock) disable iff (reset)
      $countones(way_rd_hit) <= 1)
    else begin
      fail_count++;
      $error("more than one way hits the read address");
    end

  a_victim_idle: assert property (@(posedge clock) disable iff (reset) !wr_search |-> victim == '0)
    else begin
      fail_count++;
      $error("victim is not zero while no write search is active");
    end

endmodule

/* dcache.sv */
// dcache: four-way set-associative data cache array with tree pseudo-LRU replacement
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache (
  input  logic                         clock,
  input  logic                         reset,
  input  dcache_pkg::dcache_addr_u     rd_addr,
  input  logic                         rd_search,
  input  dcache_pkg::dcache_write_t    wr_req,
  input  logic                         wr_en,
  input  logic                         wr_from_mem,
  input  logic                         wr_search,
  output logic                         rd_hit,
  output logic [`DCACHE_DATA_BITS-1:0] rd_data,
  output logic                         wr_hit,
  output dcache_pkg::dcache_victim_t   victim
);

  logic [`DCACHE_NUM_WAY-1:0]                         way_wr_en;
  logic [`DCACHE_NUM_WAY-1:0]                         victim_sel;
  logic [`DCACHE_NUM_WAY-1:0]                         way_rd_hit;
  logic [`DCACHE_NUM_WAY-1:0][`DCACHE_DATA_BITS-1:0]  way_rd_data;
  logic [`DCACHE_NUM_WAY-1:0]                         way_wr_hit;
  dcache_pkg::dcache_victim_t [`DCACHE_NUM_WAY-1:0]   way_victim;

  plru_way_select u_plru (
    .clock       (clock),
    .reset       (reset),
    .wr_en       (wr_en),
    .wr_from_mem (wr_from_mem),
    .wr_index    (wr_req.addr.fields.set_index),
    .way_wr_hit  (way_wr_hit),
    .way_wr_en   (way_wr_en),
    .victim_sel  (victim_sel)
  );

  for (genvar w = 0; w < `DCACHE_NUM_WAY; w++) begin : g_way
    cache_way u_way (
      .clock   (clock),
      .reset   (reset),
      .wr_en   (way_wr_en[w]),
      .wr_req  (wr_req),
      .rd_addr (rd_addr),
      .rd_hit  (way_rd_hit[w]),
      .rd_data (way_rd_data[w]),
      .wr_hit  (way_wr_hit[w]),
      .victim  (way_victim[w])
    );
  end

  way_merge u_merge (
    .rd_search   (rd_search),
    .wr_search   (wr_search),
    .way_rd_hit  (way_rd_hit),
    .way_rd_data (way_rd_data),
    .way_wr_hit  (way_wr_hit),
    .way_victim  (way_victim),
    .victim_sel  (victim_sel),
    .rd_hit      (rd_hit),
    .rd_data     (rd_data),
    .wr_hit      (wr_hit),
    .victim      (victim)
  );

endmodule

/* way_merge.sv */
// way_merge: combines per-way hits, picks read data and the reported victim
`timescale 1ns/1ps
`include "dcache_defines.svh"

module way_merge (
  input  logic                                            rd_search,
  input  logic                                            wr_search,
  input  logic [`DCACHE_NUM_WAY-1:0]                      way_rd_hit,
  input  logic [`DCACHE_NUM_WAY-1:0][`DCACHE_DATA_BITS-1:0] way_rd_data,
  input  logic [`DCACHE_NUM_WAY-1:0]                      way_wr_hit,
  input  dcache_pkg::dcache_victim_t [`DCACHE_NUM_WAY-1:0] way_victim,
  input  logic [`DCACHE_NUM_WAY-1:0]                      victim_sel,
  output logic                                            rd_hit,
  output logic [`DCACHE_DATA_BITS-1:0]                    rd_data,
  output logic                                            wr_hit,
  output dcache_pkg::dcache_victim_t                      victim
);

  assign rd_hit = |way_rd_hit;
  assign wr_hit = |way_wr_hit;

  // data only when exactly one way claims the address
  always_comb begin
    rd_data = `DCACHE_MISS_DATA;
    if (rd_search && $onehot(way_rd_hit)) begin
      for (int w = 0; w < `DCACHE_NUM_WAY; w++) begin
        if (way_rd_hit[w]) begin
          rd_data = way_rd_data[w];
        end
      end
    end
  end

  // victim_sel is one-hot, at most one candidate passes
  always_comb begin
    victim = '0;
    if (wr_search) begin
      for (int w = 0; w < `DCACHE_NUM_WAY; w++) begin
        if (victim_sel[w]) begin
          victim = way_victim[w];
        end
      end
    end
  end

endmodule

/* cache_way.sv */
// cache_way: line storage of one way with read and write tag compare and its victim
`timescale 1ns/1ps
`include "dcache_defines.svh"

module cache_way (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           wr_en,
  input  dcache_pkg::dcache_write_t      wr_req,
  input  dcache_pkg::dcache_addr_u       rd_addr,
  output logic                           rd_hit,
  output logic [`DCACHE_DATA_BITS-1:0]   rd_data,
  output logic                           wr_hit,
  output dcache_pkg::dcache_victim_t     victim
);

  dcache_pkg::dcache_line_t lines [`DCACHE_NUM_SETS];

  dcache_pkg::dcache_line_t      rd_line;
  dcache_pkg::dcache_line_t      wr_line;
  logic [`DCACHE_INDEX_BITS-1:0] wr_index;

  assign wr_index = wr_req.addr.fields.set_index;
  assign rd_line  = lines[rd_addr.fields.set_index];
  assign wr_line  = lines[wr_index];

  // read lookup
  assign rd_hit  = rd_line.valid && (rd_line.tag == rd_addr.fields.tag);
  assign rd_data = rd_line.data;

  // write lookup, feeds the store-hit path
  assign wr_hit = wr_line.valid && (wr_line.tag == wr_req.addr.fields.tag);

  // line a fill into this way would push out
  always_comb begin
    victim.valid     = wr_line.valid;
    victim.dirty     = wr_line.dirty;
    victim.addr.word = {wr_line.tag, wr_index, {`DCACHE_OFFSET_BITS{1'b0}}};
    victim.data      = wr_line.data;
  end

  // whole line replaced on every enabled write
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < `DCACHE_NUM_SETS; s++) begin
        lines[s] <= '0;
      end
    end else if (wr_en) begin
      lines[wr_index].valid <= wr_req.valid;
      lines[wr_index].dirty <= wr_req.dirty;
      lines[wr_index].tag   <= wr_req.addr.fields.tag;
      lines[wr_index].data  <= wr_req.data;
    end
  end

endmodule

/* plru_way_select.sv */
// plru_way_select: per-set tree pseudo-LRU state and one-hot write enables for the ways
`timescale 1ns/1ps
`include "dcache_defines.svh"

module plru_way_select (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          wr_en,
  input  logic                          wr_from_mem,
  input  logic [`DCACHE_INDEX_BITS-1:0] wr_index,
  input  logic [`DCACHE_NUM_WAY-1:0]    way_wr_hit,
  output logic [`DCACHE_NUM_WAY-1:0]    way_wr_en,
  output logic [`DCACHE_NUM_WAY-1:0]    victim_sel
);

  // a picks the half, b splits ways 0/1, c splits ways 2/3
  logic [`DCACHE_NUM_SETS-1:0] tree_a;
  logic [`DCACHE_NUM_SETS-1:0] tree_b;
  logic [`DCACHE_NUM_SETS-1:0] tree_c;

  logic a_cur;
  logic b_cur;
  logic c_cur;
  logic any_hit;
  logic fill;

  assign a_cur = tree_a[wr_index];
  assign b_cur = tree_b[wr_index];
  assign c_cur = tree_c[wr_index];

  // victim decode for the write set
  always_comb begin
    victim_sel[0] = !a_cur && !b_cur;
    victim_sel[1] = !a_cur && b_cur;
    victim_sel[2] = a_cur && !c_cur;
    victim_sel[3] = a_cur && c_cur;
  end

  assign any_hit = |way_wr_hit;

  // miss branch of the write rule
  assign fill = wr_en && wr_from_mem && !any_hit;

  // store hits go to the hitting way, fills to the victim
  always_comb begin
    if (wr_en && any_hit) begin
      way_wr_en = way_wr_hit;
    end else if (fill) begin
      way_wr_en = victim_sel;
    end else begin
      way_wr_en = '0;
    end
  end

  // only fills move the tree, so store hits keep the order
  always_ff @(posedge clock) begin
    if (reset) begin
      tree_a <= '0;
      tree_b <= '0;
      tree_c <= '0;
    end else if (fill) begin
      tree_a[wr_index] <= !a_cur;
      if (a_cur) begin
        tree_c[wr_index] <= !c_cur;
      end else begin
        tree_b[wr_index] <= !b_cur;
      end
    end
  end

endmodule

/* dcache_pkg.sv */
// dcache types: address views, stored line, write request and write-back candidate
`include "dcache_defines.svh"

package dcache_pkg;

  typedef struct packed {
    logic [`DCACHE_TAG_BITS-1:0]    tag;
    logic [`DCACHE_INDEX_BITS-1:0]  set_index;
    logic [`DCACHE_OFFSET_BITS-1:0] offset;
  } dcache_addr_t;

  // byte address as a whole word or split into its fields
  typedef union packed {
    logic [`DCACHE_ADDR_BITS-1:0] word;
    dcache_addr_t                 fields;
  } dcache_addr_u;

  typedef struct packed {
    logic                         valid;
    logic                         dirty;
    logic [`DCACHE_TAG_BITS-1:0]  tag;
    logic [`DCACHE_DATA_BITS-1:0] data;
  } dcache_line_t;

  typedef struct packed {
    dcache_addr_u                 addr;
    logic [`DCACHE_DATA_BITS-1:0] data;
    logic                         valid;
    logic                         dirty;
  } dcache_write_t;

  // addr carries a zero offset, it names the whole line
  typedef struct packed {
    logic                         valid;
    logic                         dirty;
    dcache_addr_u                 addr;
    logic [`DCACHE_DATA_BITS-1:0] data;
  } dcache_victim_t;

endpackage

/* dcache_defines.svh */
// dcache geometry: way count, set count, address field widths and the miss marker
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// tree pseudo-LRU below is built for exactly four ways
`define DCACHE_NUM_WAY 4
`define DCACHE_NUM_SETS 32

// byte address split: tag | set index | offset
`define DCACHE_INDEX_BITS 5
`define DCACHE_OFFSET_BITS 3
`define DCACHE_TAG_BITS 24
`define DCACHE_ADDR_BITS 32

// one 64-bit word per line
`define DCACHE_DATA_BITS 64

// shown on the read port whenever the lookup does not return a line
`define DCACHE_MISS_DATA 64'hDEAD_DEAD_DEAD_DEAD

`endif
